//--- hw/ray_caster.sv
`timescale 1ns/10ps

module ray_caster (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  next_ray,
  ray_if.caster ray,
  output logic  frame_last
);
  import rtx_pkg::*;

  logic [PIX_H_W-1:0]      h_cnt;
  logic [PIX_V_W-1:0]      v_cnt;
  logic                    h_end;
  logic                    v_end;
  logic signed [DIR_W-1:0] dx_next;
  logic signed [DIR_W-1:0] dy_next;

  assign h_end = (h_cnt == PIX_H_W'(SCREEN_W - 1));
  assign v_end = (v_cnt == PIX_V_W'(SCREEN_H - 1));

  // Offset from screen centre gives the direction
  assign dx_next = DIR_W'(h_cnt) - DIR_W'(SCREEN_W / 2);
  assign dy_next = DIR_W'(v_cnt) - DIR_W'(SCREEN_H / 2);

  // Raster order with wrap at the end of the frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (next_ray) begin
      if (h_end) begin
        h_cnt <= '0;
        v_cnt <= v_end ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ray.ray_valid <= 1'b0;
      frame_last    <= 1'b0;
    end else begin
      ray.ray_valid <= next_ray;
      // Held until the next request so the top can gate the last ray_done
      if (next_ray) begin
        frame_last <= h_end && v_end;
      end
    end
  end

  // Ray payload
  always_ff @(posedge clk) begin
    if (next_ray) begin
      ray.dx      <= dx_next;
      ray.dy      <= dy_next;
      ray.dz      <= DIR_W'(FOCAL);
      ray.pixel_h <= h_cnt;
      ray.pixel_v <= v_cnt;
    end
  end

  // Requests come from ray_done, so never during the strobe
  a_no_req_on_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(next_ray && ray.ray_valid)
  );

endmodule

//--- hw/ray_if.sv
`timescale 1ns/10ps

interface ray_if;
  import rtx_pkg::*;

  // Ray direction, origin is always the camera
  logic signed [DIR_W-1:0] dx;
  logic signed [DIR_W-1:0] dy;
  logic signed [DIR_W-1:0] dz;

  // Pixel that the ray belongs to
  logic [PIX_H_W-1:0] pixel_h;
  logic [PIX_V_W-1:0] pixel_v;

  // Single-cycle strobe
  logic ray_valid;

  modport caster (output dx, dy, dz, pixel_h, pixel_v, ray_valid);
  modport tracer (input dx, dy, dz, pixel_h, pixel_v, ray_valid);

endinterface

//--- hw/ray_tracer.sv
`timescale 1ns/10ps

module ray_tracer (
  input  logic                        clk,
  input  logic                        rst_n,
  ray_if.tracer                       ray,
  scene_if.tracer                     scene,
  output logic                        ray_done,
  output logic [15:0]                 pixel_rgb565,
  output logic [rtx_pkg::PIX_H_W-1:0] pixel_h,
  output logic [rtx_pkg::PIX_V_W-1:0] pixel_v,
  output logic                        busy
);
  import rtx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_TEST
  } state_t;

  state_t               state;
  logic [OBJ_IDX_W-1:0] idx;

  // Ray held for the whole object loop
  logic signed [DIR_W-1:0] dir_x;
  logic signed [DIR_W-1:0] dir_y;
  logic signed [DIR_W-1:0] dir_z;

  // Operands widened to product width
  logic signed [PROD_W-1:0] ext_dx;
  logic signed [PROD_W-1:0] ext_dy;
  logic signed [PROD_W-1:0] ext_dz;
  logic signed [PROD_W-1:0] ext_cx;
  logic signed [PROD_W-1:0] ext_cy;
  logic signed [PROD_W-1:0] ext_cz;
  logic signed [PROD_W-1:0] ext_r;

  // Registered products of the current object
  logic signed [PROD_W-1:0] dc;
  logic signed [PROD_W-1:0] dd;
  logic signed [PROD_W-1:0] cc;
  logic [15:0]              cand_color;
  logic                     cand_last;

  logic hit;
  logic finish;

  assign ext_dx = dir_x;
  assign ext_dy = dir_y;
  assign ext_dz = dir_z;
  assign ext_cx = $signed(scene.obj.cx);
  assign ext_cy = $signed(scene.obj.cy);
  assign ext_cz = $signed(scene.obj.cz);
  // Radius is unsigned, zero-extended
  assign ext_r  = {{(PROD_W - RAD_W){1'b0}}, scene.obj.radius};

  // Sphere in front of the camera and within reach of the ray
  assign hit    = (dc > 0) && (dc * dc >= dd * cc);
  assign finish = hit || cand_last || (idx == OBJ_IDX_W'(SCENE_DEPTH - 1));

  assign busy = (state != ST_IDLE);

  // Object read requests
  always_comb begin
    scene.rd_en   = 1'b0;
    scene.obj_idx = '0;
    if (state == ST_IDLE) begin
      scene.rd_en = ray.ray_valid;
    end else if (state == ST_TEST && !finish) begin
      scene.rd_en   = 1'b1;
      scene.obj_idx = idx + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      idx      <= '0;
      ray_done <= 1'b0;
    end else begin
      ray_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (ray.ray_valid) begin
            idx   <= '0;
            state <= ST_READ;
          end
        end
        // Read data lands here
        ST_READ: begin
          state <= ST_TEST;
        end
        ST_TEST: begin
          if (finish) begin
            ray_done <= 1'b1;
            state    <= ST_IDLE;
          end else begin
            idx   <= idx + 1'b1;
            state <= ST_READ;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Capture the incoming ray
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && ray.ray_valid) begin
      dir_x   <= ray.dx;
      dir_y   <= ray.dy;
      dir_z   <= ray.dz;
      pixel_h <= ray.pixel_h;
      pixel_v <= ray.pixel_v;
    end
  end

  // dc = d.c, dd = d.d, cc = c.c - r^2
  always_ff @(posedge clk) begin
    if (state == ST_READ) begin
      dc <= ext_dx * ext_cx + ext_dy * ext_cy + ext_dz * ext_cz;
      dd <= ext_dx * ext_dx + ext_dy * ext_dy + ext_dz * ext_dz;
      cc <= ext_cx * ext_cx + ext_cy * ext_cy + ext_cz * ext_cz - ext_r * ext_r;
      // RGB565 with red on top
      cand_color <= {scene.obj.color.r[7:3], scene.obj.color.g[7:2], scene.obj.color.b[7:3]};
      cand_last  <= scene.obj_last;
    end
  end

  // Lowest index hit wins, else background
  always_ff @(posedge clk) begin
    if (state == ST_TEST && finish) begin
      pixel_rgb565 <= hit ? cand_color : BG_COLOR;
    end
  end

  // The caster only sends a ray after our own ray_done
  a_no_ray_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ray.ray_valid && busy)
  );

endmodule

//--- hw/rtx_pkg.sv
package rtx_pkg;

  // Screen geometry
  localparam int SCREEN_W = 16;
  localparam int SCREEN_H = 12;
  localparam int PIX_H_W  = 4;
  localparam int PIX_V_W  = 4;

  // Fixed camera at the origin looking down +z
  localparam int FOCAL = 16;

  // Arithmetic widths
  localparam int DIR_W   = 6;
  localparam int COORD_W = 12;
  localparam int RAD_W   = 10;
  localparam int PROD_W  = 48;

  // Scene storage
  localparam int SCENE_DEPTH = 8;
  localparam int OBJ_IDX_W   = 3;

  // Dark slate, RGB565
  localparam logic [15:0] BG_COLOR = 16'h18e4;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // One sphere of the scene
  typedef struct packed {
    logic signed [COORD_W-1:0] cx;
    logic signed [COORD_W-1:0] cy;
    logic signed [COORD_W-1:0] cz;
    logic [RAD_W-1:0]          radius;
    rgb888_t                   color;
    // Final object of the scene
    logic                      last;
  } object_t;

endpackage

//--- hw/rtx_top.sv
`timescale 1ns/10ps

module rtx_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               start,
  input  logic                               scene_we,
  input  logic [rtx_pkg::OBJ_IDX_W-1:0]      scene_addr,
  input  logic signed [rtx_pkg::COORD_W-1:0] obj_cx,
  input  logic signed [rtx_pkg::COORD_W-1:0] obj_cy,
  input  logic signed [rtx_pkg::COORD_W-1:0] obj_cz,
  input  logic [rtx_pkg::RAD_W-1:0]          obj_radius,
  input  logic [7:0]                         obj_r,
  input  logic [7:0]                         obj_g,
  input  logic [7:0]                         obj_b,
  input  logic                               obj_last,
  output logic                               ray_done,
  output logic [15:0]                        pixel_rgb565,
  output logic [rtx_pkg::PIX_H_W-1:0]        pixel_h,
  output logic [rtx_pkg::PIX_V_W-1:0]        pixel_v,
  output logic                               frame_done,
  output logic                               busy
);
  import rtx_pkg::*;

  ray_if   ray_bus ();
  scene_if scene_bus ();

  logic    next_ray;
  logic    frame_last;
  object_t wobj;

  // Object fields from the host
  assign wobj = '{
    cx:     obj_cx,
    cy:     obj_cy,
    cz:     obj_cz,
    radius: obj_radius,
    color:  '{r: obj_r, g: obj_g, b: obj_b},
    last:   obj_last
  };

  // Next ray on start, or chained from ray_done until the frame ends
  assign next_ray   = start || (ray_done && !frame_last);
  assign frame_done = ray_done && frame_last;

  ray_caster ray_caster_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .next_ray   (next_ray),
    .ray        (ray_bus.caster),
    .frame_last (frame_last)
  );

  scene_buffer scene_buffer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (scene_we),
    .waddr (scene_addr),
    .wobj  (wobj),
    .rd    (scene_bus.buffer)
  );

  ray_tracer ray_tracer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ray          (ray_bus.tracer),
    .scene        (scene_bus.tracer),
    .ray_done     (ray_done),
    .pixel_rgb565 (pixel_rgb565),
    .pixel_h      (pixel_h),
    .pixel_v      (pixel_v),
    .busy         (busy)
  );

endmodule

//--- hw/scene_buffer.sv
`timescale 1ns/10ps

module scene_buffer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          we,
  input  logic [rtx_pkg::OBJ_IDX_W-1:0] waddr,
  input  rtx_pkg::object_t              wobj,
  scene_if.buffer                       rd
);
  import rtx_pkg::*;

  object_t mem [SCENE_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wobj;
    end
  end

  // Registered read data
  always_ff @(posedge clk) begin
    if (rd.rd_en) begin
      rd.obj <= mem[rd.obj_idx];
    end
  end

  // End-of-scene marker, straight from the stored bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd.obj_last <= 1'b0;
    end else if (rd.rd_en) begin
      rd.obj_last <= mem[rd.obj_idx].last;
    end
  end

  // Scene loads only while the tracer is idle
  a_no_write_during_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(rd.rd_en && we)
  );

endmodule

//--- hw/scene_if.sv
`timescale 1ns/10ps

interface scene_if;
  import rtx_pkg::*;

  logic [OBJ_IDX_W-1:0] obj_idx;
  logic                 rd_en;

  // Read data, one cycle after rd_en
  object_t              obj;
  logic                 obj_last;

  modport buffer (input obj_idx, rd_en, output obj, obj_last);
  modport tracer (output obj_idx, rd_en, input obj, obj_last);

endinterface

//--- run.sh
#!/usr/bin/env bash
# Build and run the ray tracer simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --assert \
  --top-module rtx_tb -f sim.f \
  --Mdir obj_dir -o rtx_sim

./obj_dir/rtx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"

//--- sim.f
hw/rtx_pkg.sv
hw/ray_if.sv
hw/scene_if.sv
hw/ray_caster.sv
hw/scene_buffer.sv
hw/ray_tracer.sv
hw/rtx_top.sv
verif/rtx_tb.sv

//--- verif/rtx_tb.sv
`timescale 1ns/10ps

module rtx_tb;
  import rtx_pkg::*;

  localparam int NUM_SCENES = 20;
  localparam int NUM_PIX    = SCREEN_W * SCREEN_H;
  // Worst case per pixel is well under 2*SCENE_DEPTH+4 cycles
  localparam int TIMEOUT    = NUM_SCENES * NUM_PIX * (2 * SCENE_DEPTH + 4) + 1000;

  logic                      clk;
  logic                      rst_n;
  logic                      start;
  logic                      scene_we;
  logic [OBJ_IDX_W-1:0]      scene_addr;
  logic signed [COORD_W-1:0] obj_cx;
  logic signed [COORD_W-1:0] obj_cy;
  logic signed [COORD_W-1:0] obj_cz;
  logic [RAD_W-1:0]          obj_radius;
  logic [7:0]                obj_r;
  logic [7:0]                obj_g;
  logic [7:0]                obj_b;
  logic                      obj_last;
  logic                      ray_done;
  logic [15:0]               pixel_rgb565;
  logic [PIX_H_W-1:0]        pixel_h;
  logic [PIX_V_W-1:0]        pixel_v;
  logic                      frame_done;
  logic                      busy;

  int          seed = 32'h8edf;
  int          cycle_cnt = 0;
  // Copy of what has been written into the scene memory
  object_t     scene_mem [SCENE_DEPTH];
  logic [15:0] exp_q [$];

  rtx_top rtx_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .scene_we     (scene_we),
    .scene_addr   (scene_addr),
    .obj_cx       (obj_cx),
    .obj_cy       (obj_cy),
    .obj_cz       (obj_cz),
    .obj_radius   (obj_radius),
    .obj_r        (obj_r),
    .obj_g        (obj_g),
    .obj_b        (obj_b),
    .obj_last     (obj_last),
    .ray_done     (ray_done),
    .pixel_rgb565 (pixel_rgb565),
    .pixel_h      (pixel_h),
    .pixel_v      (pixel_v),
    .frame_done   (frame_done),
    .busy         (busy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Simulation ran past %0d cycles without finishing", TIMEOUT);
      $display("Test FAILED");
      $fatal(1, "Timeout");
    end
  end

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  // Sphere mostly in view, some behind the camera
  function automatic object_t random_object(logic is_last);
    object_t o;
    o.cx       = COORD_W'(rand_range(-250, 250));
    o.cy       = COORD_W'(rand_range(-200, 200));
    o.cz       = COORD_W'(rand_range(-300, 600));
    o.radius   = RAD_W'(rand_range(8, 250));
    o.color.r  = 8'(rand_range(0, 255));
    o.color.g  = 8'(rand_range(0, 255));
    o.color.b  = 8'(rand_range(0, 255));
    o.last     = is_last;
    return o;
  endfunction

  // Lowest-indexed hit in scene order, background otherwise
  function automatic logic [15:0] model_pixel(int h, int v);
    longint      dx, dy, dz, cx, cy, cz, r, dc, dd, cc;
    logic [15:0] color;
    logic        stop;
    color = BG_COLOR;
    stop  = 1'b0;
    dx    = h - SCREEN_W / 2;
    dy    = v - SCREEN_H / 2;
    dz    = FOCAL;
    for (int i = 0; i < SCENE_DEPTH; i++) begin
      if (!stop) begin
        cx = longint'($signed(scene_mem[i].cx));
        cy = longint'($signed(scene_mem[i].cy));
        cz = longint'($signed(scene_mem[i].cz));
        r  = longint'(scene_mem[i].radius);
        dc = dx * cx + dy * cy + dz * cz;
        dd = dx * dx + dy * dy + dz * dz;
        cc = cx * cx + cy * cy + cz * cz - r * r;
        if (dc > 0 && dc * dc >= dd * cc) begin
          color = {scene_mem[i].color.r[7:3], scene_mem[i].color.g[7:2],
                   scene_mem[i].color.b[7:3]};
          stop  = 1'b1;
        end else if (scene_mem[i].last) begin
          stop = 1'b1;
        end
      end
    end
    return color;
  endfunction

  task automatic check_pixel(logic [15:0] exp, logic [15:0] act, int h, int v);
    if (act !== exp) begin
      $display("FAILED at %0t: pixel_rgb565 at (%0d,%0d) expected %h, got %h",
               $time, h, v, exp, act);
      $display("Test FAILED");
      $fatal(1, "Pixel mismatch");
    end
  endtask

  task automatic check_coord(logic [PIX_H_W-1:0] exp_h, logic [PIX_H_W-1:0] act_h,
                             logic [PIX_V_W-1:0] exp_v, logic [PIX_V_W-1:0] act_v);
    if (act_h !== exp_h || act_v !== exp_v) begin
      $display("FAILED at %0t: pixel_h/pixel_v expected (%0d,%0d), got (%0d,%0d)",
               $time, exp_h, exp_v, act_h, act_v);
      $display("Test FAILED");
      $fatal(1, "Coordinate mismatch");
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic write_object(int idx, object_t o);
    @(posedge clk);
    #1;
    scene_we   = 1'b1;
    scene_addr = OBJ_IDX_W'(idx);
    obj_cx     = o.cx;
    obj_cy     = o.cy;
    obj_cz     = o.cz;
    obj_radius = o.radius;
    obj_r      = o.color.r;
    obj_g      = o.color.g;
    obj_b      = o.color.b;
    obj_last   = o.last;
    scene_mem[idx] = o;
  endtask

  // Junk may follow the marked object and must stay invisible
  task automatic load_scene();
    int n_obj;
    n_obj = rand_range(1, SCENE_DEPTH);
    for (int i = 0; i < SCENE_DEPTH; i++) begin
      if (i < n_obj) begin
        write_object(i, random_object(i == n_obj - 1));
      end else if (rand_range(0, 1) == 1) begin
        write_object(i, random_object(1'(rand_range(0, 1))));
      end
    end
    @(posedge clk);
    #1;
    scene_we = 1'b0;
    for (int v = 0; v < SCREEN_H; v++) begin
      for (int h = 0; h < SCREEN_W; h++) begin
        exp_q.push_back(model_pixel(h, v));
      end
    end
  endtask

  task automatic check_quiet(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("ray_done", 1'b0, ray_done);
      check_flag("frame_done", 1'b0, frame_done);
      check_flag("busy", 1'b0, busy);
    end
  endtask

  task automatic run_frame();
    int   pix;
    logic busy_prev;
    pix       = 0;
    busy_prev = 1'b0;
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (pix < NUM_PIX) begin
      @(negedge clk);
      if (ray_done) begin
        // Tracer is still working on the ray the cycle before its done strobe
        check_flag("busy", 1'b1, busy_prev);
        check_coord(PIX_H_W'(pix % SCREEN_W), pixel_h, PIX_V_W'(pix / SCREEN_W), pixel_v);
        check_pixel(exp_q.pop_front(), pixel_rgb565, pix % SCREEN_W, pix / SCREEN_W);
        check_flag("frame_done", pix == NUM_PIX - 1, frame_done);
        pix++;
      end else begin
        check_flag("frame_done", 1'b0, frame_done);
      end
      busy_prev = busy;
    end
    // No extra rays once the frame has ended
    check_quiet(2 * SCENE_DEPTH + 4);
  endtask

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    scene_we   = 1'b0;
    scene_addr = '0;
    obj_cx     = '0;
    obj_cy     = '0;
    obj_cz     = '0;
    obj_radius = '0;
    obj_r      = '0;
    obj_g      = '0;
    obj_b      = '0;
    obj_last   = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_quiet(20);
    for (int s = 0; s < NUM_SCENES; s++) begin
      load_scene();
      run_frame();
    end
    $display("Test OK");
    $finish;
  end

endmodule
